//--- files.f
src/loader_pkg.sv
src/dl_if.sv
src/byte_descrambler.sv
src/header_capture.sv
src/region_decoder.sv
src/prog_write_ctrl.sv
src/rom_loader_top.sv
testbench/tb_rom_loader.sv

//--- run.sh
#!/bin/sh
# builds the rom loader testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_rom_loader -f files.f; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_rom_loader)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx '\*\* PASS \*\*'; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- src/byte_descrambler.sv
// cpu code descrambler, bitwise xor table applied to selected bytes
`timescale 1ns/1ps

module byte_descrambler import loader_pkg::*; (
    input  logic [7:0] din,
    input  logic       sel,   // byte falls in the scrambled area
    output logic [7:0] dout
);

    logic [7:0] mixed;

    // each set bit folds its mask in
    always_comb begin
        mixed = SCRAMBLE_BASE;
        for (int i = 0; i < 8; i++) begin
            if (din[i])
                mixed = mixed ^ SCRAMBLE_MASK[i];
        end
    end

    assign dout = sel ? mixed : din;  // plain bytes untouched

endmodule

//--- src/dl_if.sv
// download bus from the host, one byte per write strobe
`timescale 1ns/1ps

interface dl_if import loader_pkg::*; ();

    logic              downloading;  // high for the whole transfer
    logic [ADDR_W-1:0] addr;         // byte address
    logic [7:0]        data;
    logic              wr;           // single cycle strobe

    modport src (
        output downloading,
        output addr,
        output data,
        output wr
    );

    modport sink (
        input downloading,
        input addr,
        input data,
        input wr
    );

endinterface

//--- src/header_capture.sv
// header capture, picks region starts, descramble flags, config bytes and decoder key
`timescale 1ns/1ps

module header_capture import loader_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    dl_if.sink         dl,
    output starts_t    starts,
    output logic       decrypt,
    output logic       key_bit,
    output logic       cfg_we,
    output logic [5:0] cfg_idx,
    output logic [7:0] cfg_byte,
    output key_t       kabuki_key,
    output logic       key_valid
);

    logic take;      // byte accepted this cycle
    logic is_start;
    logic is_cfg;
    logic is_key;
    logic is_flag;
    logic last_key;

    assign take = dl.wr && dl.downloading;

    // address windows inside the header
    assign is_start = dl.addr < ADDR_W'(START_BYTES);
    assign is_cfg   = dl.addr >= ADDR_W'(START_BYTES) &&
                      dl.addr <  ADDR_W'(REGSIZE + START_HEADER);
    assign is_key   = dl.addr >= ADDR_W'(KABUKI_HEADER) &&
                      dl.addr <  ADDR_W'(KABUKI_HEADER + KABUKI_LEN);
    assign is_flag  = dl.addr == ADDR_W'(CFG_BYTE);
    assign last_key = dl.addr == ADDR_W'(KABUKI_HEADER + KABUKI_LEN - 1);

    // control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            starts    <= '1;  // all ones keeps every byte in the cpu region
            decrypt   <= 1'b0;
            key_bit   <= 1'b0;
            cfg_we    <= 1'b0;
            key_valid <= 1'b0;
        end else begin
            cfg_we <= take && is_cfg;  // single cycle per config byte
            if (take && is_start)
                starts <= {dl.data, starts[63:8]};  // little endian fill
            if (take && is_flag) begin
                decrypt <= dl.data[7];
                key_bit <= dl.data[6];  // selects odd or even bytes
            end
            if (take && last_key)
                key_valid <= 1'b1;
            if (!dl.downloading) begin
                decrypt   <= 1'b0;
                key_valid <= 1'b0;  // held until the transfer ends
            end
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (take && is_cfg) begin
            cfg_idx  <= dl.addr[5:0];
            cfg_byte <= dl.data;
        end
        if (take && is_key)
            kabuki_key <= {kabuki_key[8*KABUKI_LEN-9:0], dl.data};  // shift in from the lsb
    end

    // config strobes come from separate host writes, never back to back
    assert property (@(posedge clk) disable iff (!rst_n) cfg_we |=> !cfg_we)
        else $error("cfg_we held for two cycles");

endmodule

//--- src/loader_pkg.sv
// rom loader package with header layout, region offsets, descramble table and shared types
package loader_pkg;

    localparam int ADDR_W  = 25;  // host byte address, up to 32 MB
    localparam int PROG_AW = 22;  // sdram word address

    // header layout, byte positions in the download stream
    localparam int START_BYTES   = 8;   // four 16-bit region starts
    localparam int START_HEADER  = 16;  // start block incl. reserved bytes
    localparam int REGSIZE       = 24;  // video config bytes after the start block
    localparam int FULL_HEADER   = 64;
    localparam int KABUKI_HEADER = 48;  // first decoder key byte
    localparam int KABUKI_LEN    = 11;
    localparam int CFG_BYTE      = 39;  // carries decrypt flag and key bit

    // word offsets per region, cps1 layout
    localparam logic [PROG_AW-1:0] CPU_OFFSET = 22'h00_0000;
    localparam logic [PROG_AW-1:0] SND_OFFSET = 22'h00_0000;
    localparam logic [PROG_AW-1:0] PCM_OFFSET = 22'h01_0000;  // after sound code in bank 1
    localparam logic [PROG_AW-1:0] GFX_OFFSET = 22'h00_0000;

    localparam logic [1:0] BANK_CPU   = 2'd3;
    localparam logic [1:0] BANK_GFX   = 2'd2;
    localparam logic [1:0] BANK_OTHER = 2'd1;

    // per data bit xor terms, bit 0 first
    localparam logic [7:0] SCRAMBLE_MASK [0:7] = '{
        8'h04, 8'h21, 8'h01, 8'h50, 8'h40, 8'h06, 8'h08, 8'h88
    };
    // bits 3 and 7 are inverted in the table so their masks live in the base
    localparam logic [7:0] SCRAMBLE_BASE = 8'hD8;

    typedef enum logic [2:0] {
        HEADER,
        CPU,
        SND,
        PCM,
        GFX,
        QSND
    } region_t;

    // first member is the msb, so snd sits in bits 15:0 (header bytes 0 and 1)
    typedef struct packed {
        logic [15:0] qsnd;
        logic [15:0] gfx;
        logic [15:0] pcm;
        logic [15:0] snd;
    } starts_t;

    typedef logic [8*KABUKI_LEN-1:0] key_t;  // first key byte ends up in the msbs

endpackage

//--- src/prog_write_ctrl.sv
// sdram write request control, holds prog_we or prom_we until the memory is ready
`timescale 1ns/1ps

module prog_write_ctrl import loader_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    downloading,
    input  logic    accept,     // data byte registered this cycle
    input  region_t region,
    input  logic    prog_rdy,   // one cycle pulse from the loader
    output logic    prog_we,
    output logic    prom_we
);

    logic req_q;     // request still waiting for ready
    logic req_c;
    logic to_prom;

    // new byte or an old one still pending
    assign req_c   = accept || req_q;
    assign to_prom = region == QSND;  // q-sound internal rom has its own strobe

    always_ff @(posedge clk) begin
        if (!rst_n)
            req_q <= 1'b0;
        else
            req_q <= req_c && !prog_rdy && downloading;  // drop on ready or end
    end

    // region is held by the decoder until the next strobe
    assign prog_we = req_c && !to_prom;
    assign prom_we = req_c && to_prom;

    // a held request keeps its target, so one byte never drives both strobes
    assert property (@(posedge clk) disable iff (!rst_n) req_q |-> $stable(to_prom))
        else $error("write target changed while a request was pending");

    // each request is raised by its own accept, never on top of a pending one
    assert property (@(posedge clk) disable iff (!rst_n) req_q |-> !accept)
        else $error("new byte accepted while a request was pending");

endmodule

//--- src/region_decoder.sv
// region decoder, maps a byte address to sdram word address, bank, mask and data
`timescale 1ns/1ps

module region_decoder import loader_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    dl_if.sink                 dl,
    input  starts_t            starts,
    input  logic               decrypt,
    input  logic               key_bit,
    output logic [PROG_AW-1:0] prog_addr,
    output logic [1:0]         prog_mask,
    output logic [1:0]         prog_bank,
    output logic [7:0]         prog_byte,
    output region_t            region,
    output logic               accept
);

    logic              take;
    logic              in_hdr;
    logic [ADDR_W-1:0] bulk;        // address past the header
    logic [15:0]       kb;          // 1 KB index of bulk
    region_t           reg_c;
    logic [15:0]       reg_start;   // start of the selected region in KB
    logic [PROG_AW-1:0] reg_off;
    logic [ADDR_W-1:0] rel;         // byte address inside the region
    logic [PROG_AW-1:0] word_c;
    logic              descr_sel;
    logic [7:0]        byte_c;

    assign take   = dl.wr && dl.downloading;
    assign in_hdr = dl.addr < ADDR_W'(FULL_HEADER);
    assign bulk   = dl.addr - ADDR_W'(FULL_HEADER);
    assign kb     = {1'b0, bulk[ADDR_W-1:10]};

    // starts are ordered, first match wins
    always_comb begin
        if (in_hdr)               reg_c = HEADER;
        else if (kb < starts.snd) reg_c = CPU;
        else if (kb < starts.pcm) reg_c = SND;
        else if (kb < starts.gfx) reg_c = PCM;
        else if (kb < starts.qsnd) reg_c = GFX;
        else                      reg_c = QSND;
    end

    always_comb begin
        case (reg_c)
            SND:     begin reg_start = starts.snd; reg_off = SND_OFFSET; end
            PCM:     begin reg_start = starts.pcm; reg_off = PCM_OFFSET; end
            GFX:     begin reg_start = starts.gfx; reg_off = GFX_OFFSET; end
            default: begin reg_start = '0;         reg_off = CPU_OFFSET; end  // cpu at 0
        endcase
    end

    assign rel    = bulk - {reg_start[14:0], 10'd0};
    assign word_c = (reg_c == QSND) ? {9'd0, bulk[12:0]}  // internal rom, small
                                    : rel[PROG_AW:1] + reg_off;

    // upper half of cpu code, one byte lane only
    assign descr_sel = (reg_c == CPU) && decrypt && bulk[19] && (dl.addr[0] ^ key_bit);

    byte_descrambler descr_i (
        .din  (dl.data),
        .sel  (descr_sel),
        .dout (byte_c)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            accept <= 1'b0;
            region <= HEADER;
        end else begin
            accept <= take && !in_hdr;  // header bytes never reach sdram
            if (take)
                region <= reg_c;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            prog_addr <= word_c;
            prog_mask <= dl.addr[0] ? 2'b01 : 2'b10;  // active low lane select
            prog_bank <= (reg_c == CPU) ? BANK_CPU :
                         (reg_c == GFX) ? BANK_GFX : BANK_OTHER;
            prog_byte <= byte_c;
        end
    end

endmodule

//--- src/rom_loader_top.sv
// rom download router top, host byte stream in, sdram writes and header outputs out
`timescale 1ns/1ps

module rom_loader_top import loader_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               downloading,
    input  logic [24:0]        ioctl_addr,
    input  logic [7:0]         ioctl_data,
    input  logic               ioctl_wr,
    input  logic               prog_rdy,
    output logic [PROG_AW-1:0] prog_addr,
    output logic [15:0]        prog_data,
    output logic [1:0]         prog_mask,  // active low
    output logic [1:0]         prog_bank,
    output logic               prog_we,
    output logic               prom_we,    // q-sound internal rom
    output logic               cfg_we,
    output logic [5:0]         cfg_idx,
    output logic [7:0]         cfg_byte,
    output key_t               kabuki_key,
    output logic               key_valid
);

    starts_t    starts;
    logic       decrypt;
    logic       key_bit;
    logic [7:0] prog_byte;
    region_t    region;
    logic       accept;

    dl_if dl_bus ();

    assign dl_bus.downloading = downloading;
    assign dl_bus.addr        = ioctl_addr;
    assign dl_bus.data        = ioctl_data;
    assign dl_bus.wr          = ioctl_wr;

    header_capture hdr_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .dl         (dl_bus.sink),
        .starts     (starts),
        .decrypt    (decrypt),
        .key_bit    (key_bit),
        .cfg_we     (cfg_we),
        .cfg_idx    (cfg_idx),
        .cfg_byte   (cfg_byte),
        .kabuki_key (kabuki_key),
        .key_valid  (key_valid)
    );

    region_decoder dec_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .dl        (dl_bus.sink),
        .starts    (starts),
        .decrypt   (decrypt),
        .key_bit   (key_bit),
        .prog_addr (prog_addr),
        .prog_mask (prog_mask),
        .prog_bank (prog_bank),
        .prog_byte (prog_byte),
        .region    (region),
        .accept    (accept)
    );

    prog_write_ctrl wr_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .accept      (accept),
        .region      (region),
        .prog_rdy    (prog_rdy),
        .prog_we     (prog_we),
        .prom_we     (prom_we)
    );

    assign prog_data = {2{prog_byte}};  // mask picks the lane

endmodule

//--- testbench/tb_rom_loader.sv
// rom loader testbench, lfsr driven image against a reference model with an sdram ready model
`timescale 1ns/1ps

module tb_rom_loader import loader_pkg::*; ();

    localparam int N_DATA  = 300;                       // random bulk bytes
    localparam int IMG_LEN = FULL_HEADER + N_DATA + 1;  // plus the aborted byte
    localparam int TIMEOUT = 8 * IMG_LEN + 200;

    logic               clk, rst_n, downloading, ioctl_wr, prog_rdy;
    logic [ADDR_W-1:0]  ioctl_addr;
    logic [7:0]         ioctl_data;
    logic [PROG_AW-1:0] prog_addr;
    logic [15:0]        prog_data;
    logic [1:0]         prog_mask, prog_bank;
    logic               prog_we, prom_we, cfg_we, key_valid;
    logic [5:0]         cfg_idx;
    logic [7:0]         cfg_byte;
    key_t               kabuki_key;

    logic [15:0] lfsr_q;              // random source
    starts_t     st;                  // region starts as sent in the header
    logic [7:0]  hdr [FULL_HEADER];
    key_t        exp_key;
    logic        key_bit;
    int          cycles;

    rom_loader_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // run limit from the image length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout, download still running after %0d cycles", cycles);
            abort_run();
        end
    end

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};  // one step per bit
        end
    endtask

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [PROG_AW-1:0] got, exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ctl(input string name, input logic [1:0] got, exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got %b exp %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got %b exp %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_key(input string name, input key_t got, exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // region from the KB index past the header
    function automatic region_t model_region(input logic [ADDR_W-1:0] a);
        logic [ADDR_W-1:0] kb;
        kb = (a - ADDR_W'(FULL_HEADER)) >> 10;
        if (a < ADDR_W'(FULL_HEADER)) return HEADER;
        if (kb < ADDR_W'(st.snd)) return CPU;
        if (kb < ADDR_W'(st.pcm)) return SND;
        if (kb < ADDR_W'(st.gfx)) return PCM;
        if (kb < ADDR_W'(st.qsnd)) return GFX;
        return QSND;
    endfunction

    function automatic logic [PROG_AW-1:0] model_word(input logic [ADDR_W-1:0] a,
                                                      input region_t r);
        logic [ADDR_W-1:0]  bulk;
        logic [15:0]        base;
        logic [PROG_AW-1:0] off;
        bulk = a - ADDR_W'(FULL_HEADER);
        base = (r == SND) ? st.snd : (r == PCM) ? st.pcm : (r == GFX) ? st.gfx : 16'd0;
        off  = (r == SND) ? SND_OFFSET : (r == PCM) ? PCM_OFFSET :
               (r == GFX) ? GFX_OFFSET : CPU_OFFSET;
        if (r == QSND)
            return PROG_AW'(bulk[12:0]);  // internal rom, byte index kept
        return PROG_AW'((bulk - ADDR_W'({base, 10'd0})) >> 1) + off;
    endfunction

    function automatic logic [7:0] model_data(input logic [ADDR_W-1:0] a, input logic [7:0] b);
        logic [ADDR_W-1:0] bulk;
        logic [7:0]        col;
        logic [7:0]        res;
        bulk = a - ADDR_W'(FULL_HEADER);
        if (model_region(a) != CPU || !hdr[CFG_BYTE][7] || !bulk[19] || a[0] == key_bit)
            return b;
        // out bit j is the parity of the input bits whose mask reaches j
        for (int j = 0; j < 8; j++) begin
            for (int i = 0; i < 8; i++)
                col[i] = SCRAMBLE_MASK[i][j];
            res[j] = SCRAMBLE_BASE[j] ^ (^(b & col));
        end
        return res;
    endfunction

    function automatic logic [1:0] strobe_exp(input logic [ADDR_W-1:0] a);
        return (model_region(a) == QSND) ? 2'b01 : 2'b10;  // {prog_we, prom_we}
    endfunction

    // one host write, returns at the negedge after the dut sampled it
    task automatic strobe_byte(input logic [ADDR_W-1:0] a, input logic [7:0] b);
        @(posedge clk);
        ioctl_addr <= a;
        ioctl_data <= b;
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr   <= 1'b0;
        @(negedge clk);
    endtask

    task automatic send_header_byte(input int idx);
        logic is_cfg;
        is_cfg = idx >= START_BYTES && idx < REGSIZE + START_HEADER;
        strobe_byte(ADDR_W'(idx), hdr[idx]);
        check_flag("cfg_we", cfg_we, is_cfg);
        if (is_cfg) begin
            check_byte("cfg_idx", {2'b00, cfg_idx}, 8'(idx));
            check_byte("cfg_byte", cfg_byte, hdr[idx]);
        end
        check_ctl("prog_we/prom_we", {prog_we, prom_we}, 2'b00);  // header never written
        check_flag("key_valid", key_valid, idx >= KABUKI_HEADER + KABUKI_LEN - 1);
        @(posedge clk);
        @(negedge clk);
        check_flag("cfg_we", cfg_we, 1'b0);  // single cycle pulse
    endtask

    // random address well inside one of the five regions
    task automatic pick_addr(output logic [ADDR_W-1:0] a);
        logic [31:0] r;
        logic [31:0] off;
        logic [15:0] base;
        int          sel;
        int          w;
        rand_bits(3, r);
        sel  = int'(r % 32'd5);
        base = (sel == 1) ? st.snd : (sel == 2) ? st.pcm :
               (sel == 3) ? st.gfx : (sel == 4) ? st.qsnd : 16'd0;
        w    = (sel == 1 || sel == 4) ? 16 : (sel == 2) ? 18 : 20;  // below the region size
        rand_bits(w, off);
        a = ADDR_W'(FULL_HEADER) + ADDR_W'({base, 10'd0}) + ADDR_W'(off);
    endtask

    task automatic check_write(input logic [ADDR_W-1:0] a, input logic [7:0] b);
        region_t rg;
        rg = model_region(a);
        check_ctl("prog_we/prom_we", {prog_we, prom_we}, strobe_exp(a));
        check_word("prog_addr", prog_addr, model_word(a, rg));
        check_ctl("prog_bank", prog_bank,
                  (rg == CPU) ? BANK_CPU : (rg == GFX) ? BANK_GFX : BANK_OTHER);
        check_ctl("prog_mask", prog_mask, a[0] ? 2'b01 : 2'b10);
        check_byte("prog_data hi", prog_data[15:8], model_data(a, b));
        check_byte("prog_data lo", prog_data[7:0], model_data(a, b));
    endtask

    // sdram side, ready after 0 to 3 busy cycles
    task automatic serve_request(input logic [ADDR_W-1:0] a);
        logic [31:0] r;
        rand_bits(2, r);
        repeat (int'(r)) begin
            @(posedge clk);
            @(negedge clk);
            check_ctl("prog_we/prom_we", {prog_we, prom_we}, strobe_exp(a));  // held
        end
        @(posedge clk);
        prog_rdy <= 1'b1;
        @(negedge clk);
        check_ctl("prog_we/prom_we", {prog_we, prom_we}, strobe_exp(a));
        @(posedge clk);
        prog_rdy <= 1'b0;
        @(negedge clk);
        check_ctl("prog_we/prom_we", {prog_we, prom_we}, 2'b00);
        rand_bits(1, r);
        if (r[0])
            @(posedge clk);  // idle gap
    endtask

    initial begin
        logic [31:0]       r;
        logic [ADDR_W-1:0] a;
        lfsr_q = 16'd46440;
        rst_n       <= 1'b0;
        downloading <= 1'b0;
        ioctl_addr  <= '0;
        ioctl_data  <= '0;
        ioctl_wr    <= 1'b0;
        prog_rdy    <= 1'b0;

        // header image, starts ordered so every region gets bytes
        for (int i = 0; i < FULL_HEADER; i++) begin
            rand_bits(8, r);
            hdr[i] = r[7:0];
        end
        rand_bits(8, r);
        st.snd  = 16'd1024 + 16'(r);  // cpu reaches past bulk bit 19
        rand_bits(6, r);
        st.pcm  = st.snd + 16'd64 + 16'(r);
        rand_bits(8, r);
        st.gfx  = st.pcm + 16'd256 + 16'(r);
        rand_bits(8, r);
        st.qsnd = st.gfx + 16'd1024 + 16'(r);
        for (int i = 0; i < START_BYTES; i++)
            hdr[i] = st[8*i +: 8];    // little endian
        hdr[CFG_BYTE][7] = 1'b1;      // decrypt on, bit 6 stays random
        key_bit = hdr[CFG_BYTE][6];
        exp_key = '0;
        for (int i = 0; i < KABUKI_LEN; i++)
            exp_key = {exp_key[8*KABUKI_LEN-9:0], hdr[KABUKI_HEADER + i]};

        repeat (4) @(posedge clk);
        rst_n       <= 1'b1;
        downloading <= 1'b1;
        @(negedge clk);
        check_ctl("prog_we/prom_we", {prog_we, prom_we}, 2'b00);
        check_flag("cfg_we", cfg_we, 1'b0);
        check_flag("key_valid", key_valid, 1'b0);

        for (int i = 0; i < FULL_HEADER; i++)
            send_header_byte(i);
        check_flag("key_valid", key_valid, 1'b1);
        check_key("kabuki_key", kabuki_key, exp_key);

        for (int n = 0; n < N_DATA; n++) begin
            pick_addr(a);
            rand_bits(8, r);
            strobe_byte(a, r[7:0]);
            check_write(a, r[7:0]);
            serve_request(a);
        end

        // last byte never gets ready, the end of the transfer drops it
        pick_addr(a);
        rand_bits(8, r);
        strobe_byte(a, r[7:0]);
        check_write(a, r[7:0]);
        @(posedge clk);
        downloading <= 1'b0;
        @(negedge clk);
        check_ctl("prog_we/prom_we", {prog_we, prom_we}, strobe_exp(a));
        @(posedge clk);
        @(negedge clk);
        check_ctl("prog_we/prom_we", {prog_we, prom_we}, 2'b00);
        check_flag("key_valid", key_valid, 1'b0);

        $display("** PASS **");
        $finish;
    end

endmodule
